// ==== Makefile ====
# Verilator flow for the counter host testbench

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f vlog.f --top-module counter_host_tb -Mdir obj_dir

# Pass only if the pass message shows up in the simulation output
run: compile
	@out=$$(./obj_dir/Vcounter_host_tb +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

// ==== dv/counter_host_props.sv ====
// #########################################################################
// Counter host checks: handshake order, strobe width and result rules
// #########################################################################

`timescale 1ns/100ps

module counter_host_props #(
    parameter int COUNTER_WIDTH = counter_host_pkg::DEF_COUNTER_WIDTH
) (
    input logic                     clk,
    input logic                     rst,
    input logic                     cmd_req,
    input logic                     cmd_ack,
    input logic                     exec_strobe,
    input logic                     force_clear,
    input logic                     overflow,
    input logic                     underflow,
    input logic                     zero,
    input logic [COUNTER_WIDTH-1:0] counter_value
);

    // Watched by the testbench
    int unsigned fail_count = 0;

    ack_needs_req: assert property (
        @(posedge clk) disable iff (rst) $rose(cmd_ack) |-> cmd_req
    ) else begin
        fail_count++;
        $error("cmd_ack rose while cmd_req was low");
    end

    // Req low at the edge that drops ack
    ack_falls_after_req: assert property (
        @(posedge clk) disable iff (rst) $fell(cmd_ack) |-> !$past(cmd_req)
    ) else begin
        fail_count++;
        $error("cmd_ack fell while cmd_req was still high");
    end

    strobe_one_cycle: assert property (
        @(posedge clk) disable iff (rst) exec_strobe |=> (!exec_strobe && cmd_ack)
    ) else begin
        fail_count++;
        $error("exec_strobe was not a single cycle followed by cmd_ack");
    end

    // Value moves two cycles after a strobe or one after a clear
    value_moves_on_command: assert property (
        @(posedge clk) disable iff (rst)
            $changed(counter_value) |-> $past(exec_strobe, 2) || $past(force_clear)
    ) else begin
        fail_count++;
        $error("counter_value changed with no command or clear behind it");
    end

    clear_empties_counter: assert property (
        @(posedge clk) disable iff (rst) force_clear |=> (counter_value == '0) && zero
    ) else begin
        fail_count++;
        $error("counter_value not zero after force_clear");
    end

    flags_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(overflow && underflow)
    ) else begin
        fail_count++;
        $error("overflow and underflow both set");
    end

endmodule

bind counter_host_top counter_host_props #(
    .COUNTER_WIDTH(COUNTER_WIDTH)
) u_props (
    .clk          (clk),
    .rst          (rst),
    .cmd_req      (cmd_req),
    .cmd_ack      (cmd_ack),
    .exec_strobe  (exec_strobe),
    .force_clear  (force_clear),
    .overflow     (overflow),
    .underflow    (underflow),
    .zero         (zero),
    .counter_value(counter_value)
);

// ==== dv/counter_host_tb.sv ====
// #########################################################################
// Counter host testbench: random req/ack commands against a counter model
// #########################################################################

`timescale 1ns/100ps

module counter_host_tb;

    localparam int CW          = counter_host_pkg::DEF_COUNTER_WIDTH;
    localparam int CMAX        = counter_host_pkg::DEF_COUNT_MAX;
    localparam int CLK_NS      = 8;
    localparam int N_CMDS      = 400;
    localparam int ACK_LIMIT   = 16;
    localparam int WATCHDOG_NS = N_CMDS * 10 * CLK_NS + 8 * CLK_NS;

    logic                        clk = 1'b0;
    logic                        rst;
    logic                        cmd_req;
    counter_host_pkg::count_op_e cmd_op;
    logic [CW-1:0]               cmd_data;
    logic                        cmd_ack;
    logic [CW-1:0]               counter_value;
    logic                        overflow;
    logic                        underflow;
    logic                        zero;
    logic                        force_clear;

    logic [31:0] rng;
    int          model_value;
    bit          model_ovf;
    bit          model_unf;
    bit          ovf_hit;
    bit          unf_hit;
    int          clear_pulses = 0;
    int          clears;

    counter_host_top #(
        .COUNTER_WIDTH(CW),
        .COUNT_MAX    (CMAX)
    ) DUT (
        .clk          (clk),
        .rst          (rst),
        .cmd_req      (cmd_req),
        .cmd_op       (cmd_op),
        .cmd_data     (cmd_data),
        .cmd_ack      (cmd_ack),
        .counter_value(counter_value),
        .overflow     (overflow),
        .underflow    (underflow),
        .zero         (zero),
        .force_clear  (force_clear)
    );

    always #(CLK_NS / 2) clk = ~clk;

    // Mid-cycle sampling of the clear pulse and the bound checks
    always @(negedge clk) begin
        if (force_clear) begin
            clear_pulses++;
        end
        if (DUT.u_props.fail_count != 0) begin
            $display("A bound handshake or counter assertion failed");
            $display("Simulation FAILED");
            $fatal(1);
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all commands finished");
        $display("Simulation FAILED");
        $fatal(1);
    end

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            rng   = lfsr_next(rng);
            value = (value << 1) | int'(rng[0]);
        end
    endtask

    task automatic check_int(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("ERR t=%0t %s got %0d expected %0d", $time, name, got, exp);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    task automatic compare_outputs();
        check_int("counter_value", int'(counter_value), model_value);
        check_int("zero", int'(zero), int'(model_value == 0));
        check_int("overflow", int'(overflow), int'(model_ovf));
        check_int("underflow", int'(underflow), int'(model_unf));
    endtask

    // Counter rules: load, wrap at the limit, wrap below zero
    task automatic apply_model(input counter_host_pkg::count_op_e op, input int data);
        int nv;
        bit wrap_up;
        bit wrap_dn;
        wrap_up = (op == counter_host_pkg::OP_UP) && (model_value >= CMAX);
        wrap_dn = (op == counter_host_pkg::OP_DOWN) && (model_value == 0);
        case (op)
            counter_host_pkg::OP_LOAD: nv = data;
            counter_host_pkg::OP_UP:   nv = wrap_up ? 0 : model_value + 1;
            counter_host_pkg::OP_DOWN: nv = wrap_dn ? CMAX : model_value - 1;
            default:                   nv = model_value;
        endcase
        if (wrap_up || wrap_dn) begin
            model_ovf = wrap_up;
            model_unf = wrap_dn;
        end else if (nv != model_value) begin
            model_ovf = 1'b0;
            model_unf = 1'b0;
        end
        model_value = nv;
    endtask

    task automatic wait_ack(input logic level);
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > ACK_LIMIT) begin
                $display("Handshake stalled, cmd_ack never went to %0b", level);
                $display("Simulation FAILED");
                $fatal(1);
            end
        end while (cmd_ack !== level);
    endtask

    task automatic send_cmd(input counter_host_pkg::count_op_e op, input int data,
                            input int hold);
        cmd_op   = op;
        cmd_data = CW'(data);
        cmd_req  = 1'b1;
        wait_ack(1'b1);
        // Result registers one cycle after ack
        @(posedge clk);
        #1;
        apply_model(op, data);
        if (clear_pulses != clears) begin
            model_value = 0;
            model_ovf   = 1'b0;
            model_unf   = 1'b0;
            clears      = clear_pulses;
        end
        ovf_hit = ovf_hit || model_ovf;
        unf_hit = unf_hit || model_unf;
        compare_outputs();
        // Master stalls with req held
        repeat (hold) begin
            @(posedge clk);
            #1;
        end
        compare_outputs();
        cmd_req = 1'b0;
        wait_ack(1'b0);
    endtask

    initial begin
        int op_bits;
        int pick;
        int data;
        int hold;
        rng         = 32'h2a02;
        rst         = 1'b1;
        cmd_req     = 1'b0;
        cmd_op      = counter_host_pkg::OP_NOP;
        cmd_data    = '0;
        model_value = 0;
        model_ovf   = 1'b0;
        model_unf   = 1'b0;
        ovf_hit     = 1'b0;
        unf_hit     = 1'b0;
        clears      = 0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        compare_outputs();
        check_int("cmd_ack", int'(cmd_ack), 0);
        check_int("force_clear", int'(force_clear), 0);

        // Both wraps first, then plain steps
        send_cmd(counter_host_pkg::OP_LOAD, CMAX, 0);
        send_cmd(counter_host_pkg::OP_UP, 0, 0);
        send_cmd(counter_host_pkg::OP_DOWN, 0, 1);
        send_cmd(counter_host_pkg::OP_LOAD, 5, 2);
        send_cmd(counter_host_pkg::OP_UP, 0, 0);
        send_cmd(counter_host_pkg::OP_DOWN, 0, 3);

        for (int n = 6; n < N_CMDS; n++) begin
            take_bits(2, op_bits);
            take_bits(2, pick);
            take_bits(CW, data);
            take_bits(2, hold);
            // Loads often land on the wrap points
            if (pick == 0) begin
                data = CMAX;
            end else if (pick == 1) begin
                data = 0;
            end
            send_cmd(counter_host_pkg::count_op_e'(op_bits[1:0]), data, hold);
        end

        if (clears == 0 || !ovf_hit || !unf_hit) begin
            $display("Coverage hole: clears %0d, overflow seen %0b, underflow seen %0b",
                     clears, ovf_hit, unf_hit);
            $display("Simulation FAILED");
            $fatal(1);
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

// ==== src/cmd_decode.sv ====
// #########################################################################
// Command decoder: four-phase req/ack port, one execute strobe per command
// #########################################################################

`timescale 1ns/100ps

module cmd_decode #(
    parameter int COUNTER_WIDTH = counter_host_pkg::DEF_COUNTER_WIDTH,
    parameter int COUNT_MAX     = counter_host_pkg::DEF_COUNT_MAX
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cmd_req,
    input  counter_host_pkg::count_op_e cmd_op,
    input  logic [COUNTER_WIDTH-1:0]    cmd_data,
    output logic                        cmd_ack,
    output logic                        exec_strobe,
    output counter_host_pkg::count_op_e exec_op,
    output logic [COUNTER_WIDTH-1:0]    exec_data
);

    counter_host_pkg::decode_state_e state;
    counter_host_pkg::decode_state_e state_nxt;

    // A load must be able to reach the wrap limit
    if (COUNT_MAX >= (1 << COUNTER_WIDTH)) begin : g_max_check
        $error("cmd_decode: COUNT_MAX does not fit in COUNTER_WIDTH bits");
    end

    always_comb begin
        state_nxt = state;
        case (state)
            counter_host_pkg::ST_IDLE: begin
                if (cmd_req) begin
                    state_nxt = counter_host_pkg::ST_ISSUE;
                end
            end
            // Strobe lasts exactly one cycle
            counter_host_pkg::ST_ISSUE: begin
                state_nxt = counter_host_pkg::ST_WAIT_DROP;
            end
            counter_host_pkg::ST_WAIT_DROP: begin
                if (!cmd_req) begin
                    state_nxt = counter_host_pkg::ST_IDLE;
                end
            end
            default: state_nxt = counter_host_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= counter_host_pkg::ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Hold op and data steady through the strobe
    always_ff @(posedge clk) begin
        if (state == counter_host_pkg::ST_IDLE && cmd_req) begin
            exec_op   <= cmd_op;
            exec_data <= cmd_data;
        end
    end

    assign exec_strobe = (state == counter_host_pkg::ST_ISSUE);
    // Ack stays up until the master drops req
    assign cmd_ack     = (state == counter_host_pkg::ST_WAIT_DROP);

endmodule

// ==== src/count_execute.sv ====
// #########################################################################
// Execute stage: up/down counter with load, wrap, clear and wrap events
// #########################################################################

`timescale 1ns/100ps

module count_execute #(
    parameter int COUNTER_WIDTH = counter_host_pkg::DEF_COUNTER_WIDTH,
    parameter int COUNT_MAX     = counter_host_pkg::DEF_COUNT_MAX
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        exec_strobe,
    input  counter_host_pkg::count_op_e exec_op,
    input  logic [COUNTER_WIDTH-1:0]    exec_data,
    input  logic                        force_clear,
    output logic                        count_step,
    output logic [COUNTER_WIDTH-1:0]    counter_next,
    output logic                        ovf_event,
    output logic                        unf_event
);

    localparam logic [COUNTER_WIDTH-1:0] MAX_VAL = COUNTER_WIDTH'(COUNT_MAX);

    logic [COUNTER_WIDTH-1:0] count_q;
    logic                     do_load;
    logic                     do_up;
    logic                     do_down;

    // Clear beats any command in the same cycle
    assign do_load = exec_strobe && !force_clear && (exec_op == counter_host_pkg::OP_LOAD);
    assign do_up   = exec_strobe && !force_clear && (exec_op == counter_host_pkg::OP_UP);
    assign do_down = exec_strobe && !force_clear && (exec_op == counter_host_pkg::OP_DOWN);

    // Pattern advances only on a real step
    assign count_step = do_up || do_down;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count_q   <= '0;
            ovf_event <= 1'b0;
            unf_event <= 1'b0;
        end else begin
            ovf_event <= 1'b0;
            unf_event <= 1'b0;
            if (force_clear) begin
                count_q <= '0;
            end else if (do_load) begin
                count_q <= exec_data;
            end else if (do_up) begin
                // Loads above the limit wrap on the next up too
                if (count_q >= MAX_VAL) begin
                    count_q   <= '0;
                    ovf_event <= 1'b1;
                end else begin
                    count_q <= count_q + 1'b1;
                end
            end else if (do_down) begin
                if (count_q == '0) begin
                    count_q   <= MAX_VAL;
                    unf_event <= 1'b1;
                end else begin
                    count_q <= count_q - 1'b1;
                end
            end
        end
    end

    assign counter_next = count_q;

endmodule

// ==== src/count_result.sv ====
// #########################################################################
// Result stage: visible counter value and zero/overflow/underflow flags
// #########################################################################

`timescale 1ns/100ps

module count_result #(
    parameter int COUNTER_WIDTH = counter_host_pkg::DEF_COUNTER_WIDTH,
    parameter int COUNT_MAX     = counter_host_pkg::DEF_COUNT_MAX
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [COUNTER_WIDTH-1:0] counter_next,
    input  logic                     ovf_event,
    input  logic                     unf_event,
    input  logic                     force_clear,
    output logic [COUNTER_WIDTH-1:0] counter_value,
    output logic                     overflow,
    output logic                     underflow,
    output logic                     zero
);

    logic new_result;

    // With a zero limit both wraps would leave the value unchanged
    if (COUNT_MAX < 1) begin : g_max_check
        $error("count_result: COUNT_MAX must be at least 1");
    end

    // A wrap event or a moved value replaces the old flags
    assign new_result = ovf_event || unf_event || (counter_next != counter_value);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            counter_value <= '0;
            overflow      <= 1'b0;
            underflow     <= 1'b0;
        end else if (force_clear) begin
            counter_value <= '0;
            overflow      <= 1'b0;
            underflow     <= 1'b0;
        end else begin
            counter_value <= counter_next;
            if (new_result) begin
                overflow  <= ovf_event;
                underflow <= unf_event;
            end
        end
    end

    assign zero = (counter_value == '0);

endmodule

// ==== src/counter_host_pkg.sv ====
// #########################################################################
// Counter host shared types: command opcodes, decoder states, defaults
// #########################################################################

package counter_host_pkg;

    // Command opcodes on the req/ack port
    typedef enum logic [1:0] {
        OP_NOP  = 2'd0,
        OP_LOAD = 2'd1,
        OP_UP   = 2'd2,
        OP_DOWN = 2'd3
    } count_op_e;

    // Four-phase handshake sequencing
    typedef enum logic [1:0] {
        ST_IDLE      = 2'd0,
        ST_ISSUE     = 2'd1,
        ST_WAIT_DROP = 2'd2
    } decode_state_e;

    // Counter defaults
    localparam int DEF_COUNTER_WIDTH = 12;
    localparam int DEF_COUNT_MAX     = 2048;

    // Pattern generator start state
    localparam logic [27:0] DEF_PATTERN_SEED = 28'hFEEDBEE;

    // Sequence trigger key, upper nibble of a pattern byte
    localparam logic [3:0] TRIG_KEY_NIBBLE = 4'hA;

    // Matching bytes needed before the clear fires
    localparam int TRIG_MATCHES = 4;

endpackage

// ==== src/counter_host_top.sv ====
// #########################################################################
// Counter host top: decode, execute, pattern, trigger and result stages
// #########################################################################

`timescale 1ns/100ps

module counter_host_top #(
    parameter int          COUNTER_WIDTH = counter_host_pkg::DEF_COUNTER_WIDTH,
    parameter int          COUNT_MAX     = counter_host_pkg::DEF_COUNT_MAX,
    parameter logic [27:0] PATTERN_SEED  = counter_host_pkg::DEF_PATTERN_SEED
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cmd_req,
    input  counter_host_pkg::count_op_e cmd_op,
    input  logic [COUNTER_WIDTH-1:0]    cmd_data,
    output logic                        cmd_ack,
    output logic [COUNTER_WIDTH-1:0]    counter_value,
    output logic                        overflow,
    output logic                        underflow,
    output logic                        zero,
    output logic                        force_clear
);

    logic                        exec_strobe;
    counter_host_pkg::count_op_e exec_op;
    logic [COUNTER_WIDTH-1:0]    exec_data;
    logic                        count_step;
    logic [7:0]                  pattern_byte;
    logic [COUNTER_WIDTH-1:0]    counter_next;
    logic                        ovf_event;
    logic                        unf_event;

    cmd_decode #(
        .COUNTER_WIDTH(COUNTER_WIDTH),
        .COUNT_MAX    (COUNT_MAX)
    ) u_decode (
        .clk        (clk),
        .rst        (rst),
        .cmd_req    (cmd_req),
        .cmd_op     (cmd_op),
        .cmd_data   (cmd_data),
        .cmd_ack    (cmd_ack),
        .exec_strobe(exec_strobe),
        .exec_op    (exec_op),
        .exec_data  (exec_data)
    );

    count_execute #(
        .COUNTER_WIDTH(COUNTER_WIDTH),
        .COUNT_MAX    (COUNT_MAX)
    ) u_execute (
        .clk         (clk),
        .rst         (rst),
        .exec_strobe (exec_strobe),
        .exec_op     (exec_op),
        .exec_data   (exec_data),
        .force_clear (force_clear),
        .count_step  (count_step),
        .counter_next(counter_next),
        .ovf_event   (ovf_event),
        .unf_event   (unf_event)
    );

    // Runs beside the counter and feeds the trigger
    pattern_gen #(
        .PATTERN_SEED(PATTERN_SEED)
    ) u_pattern (
        .clk         (clk),
        .rst         (rst),
        .count_step  (count_step),
        .pattern_byte(pattern_byte)
    );

    seq_trigger u_trigger (
        .clk         (clk),
        .rst         (rst),
        .count_step  (count_step),
        .pattern_byte(pattern_byte),
        .force_clear (force_clear)
    );

    count_result #(
        .COUNTER_WIDTH(COUNTER_WIDTH),
        .COUNT_MAX    (COUNT_MAX)
    ) u_result (
        .clk          (clk),
        .rst          (rst),
        .counter_next (counter_next),
        .ovf_event    (ovf_event),
        .unf_event    (unf_event),
        .force_clear  (force_clear),
        .counter_value(counter_value),
        .overflow     (overflow),
        .underflow    (underflow),
        .zero         (zero)
    );

endmodule

// ==== src/pattern_gen.sv ====
// #########################################################################
// Pattern generator: 28-bit LFSR plus byte selector, steps on each count
// #########################################################################

`timescale 1ns/100ps

module pattern_gen #(
    parameter logic [27:0] PATTERN_SEED = counter_host_pkg::DEF_PATTERN_SEED
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       count_step,
    output logic [7:0] pattern_byte
);

    logic [27:0] lfsr;
    logic [2:0]  byte_sel;
    logic        feedback;

    // Fibonacci taps 27, 22, 16, 3
    assign feedback = lfsr[27] ^ lfsr[22] ^ lfsr[16] ^ lfsr[3];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr     <= PATTERN_SEED;
            byte_sel <= 3'd0;
        end else if (count_step) begin
            lfsr     <= {lfsr[26:0], feedback};
            byte_sel <= byte_sel + 3'd1;
        end
    end

    // Four plain slices, then four XOR mixes of them
    always_comb begin
        case (byte_sel)
            3'd0:    pattern_byte = lfsr[7:0];
            3'd1:    pattern_byte = lfsr[15:8];
            3'd2:    pattern_byte = lfsr[23:16];
            3'd3:    pattern_byte = lfsr[27:20];
            3'd4:    pattern_byte = lfsr[7:0] ^ lfsr[15:8];
            3'd5:    pattern_byte = lfsr[23:16] ^ lfsr[7:0];
            3'd6:    pattern_byte = lfsr[27:20] ^ lfsr[15:8];
            default: pattern_byte = lfsr[27:20] ^ lfsr[7:0];
        endcase
    end

endmodule

// ==== src/seq_trigger.sv ====
// #########################################################################
// Sequence trigger: counts key bytes in the pattern, pulses a sync clear
// #########################################################################

`timescale 1ns/100ps

module seq_trigger (
    input  logic       clk,
    input  logic       rst,
    input  logic       count_step,
    input  logic [7:0] pattern_byte,
    output logic       force_clear
);

    localparam int MW = $clog2(counter_host_pkg::TRIG_MATCHES + 1);
    localparam logic [MW-1:0] LAST_MATCH = MW'(counter_host_pkg::TRIG_MATCHES - 1);

    logic [MW-1:0] match_cnt;
    logic          key_hit;

    // Only bytes seen on a real count step are considered
    assign key_hit = count_step && (pattern_byte[7:4] == counter_host_pkg::TRIG_KEY_NIBBLE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            match_cnt   <= '0;
            force_clear <= 1'b0;
        end else begin
            force_clear <= 1'b0;
            if (key_hit) begin
                if (match_cnt == LAST_MATCH) begin
                    // Fire once and start counting again
                    match_cnt   <= '0;
                    force_clear <= 1'b1;
                end else begin
                    match_cnt <= match_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// ==== vlog.f ====
src/counter_host_pkg.sv
src/cmd_decode.sv
src/pattern_gen.sv
src/seq_trigger.sv
src/count_execute.sv
src/count_result.sv
src/counter_host_top.sv
dv/counter_host_props.sv
dv/counter_host_tb.sv
